/* common/openmips_cfg.svh */
`ifndef OPENMIPS_CFG_SVH
`define OPENMIPS_CFG_SVH

////////////////////
// datapath sizing

`define OPENMIPS_DW       32
`define OPENMIPS_REG_NUM  32
`define OPENMIPS_RAW      5

////////////////////
// fetch

`define OPENMIPS_RESET_PC 32'h0000_0000

`endif

/* common/openmips_pkg.sv */
`include "openmips_cfg.svh"

package openmips_pkg;

  ////////////////////
  // execute control

  typedef enum logic [2:0] {
    ALUSEL_NOP   = 3'b000,
    ALUSEL_LOGIC = 3'b001,
    ALUSEL_SHIFT = 3'b010
  } alusel_e;

  typedef enum logic [7:0] {
    ALUOP_NOP = 8'b0000_0000,
    ALUOP_OR  = 8'b0010_0101,
    ALUOP_AND = 8'b0010_0100,
    ALUOP_XOR = 8'b0010_0110,
    ALUOP_NOR = 8'b0010_0111,
    ALUOP_LUI = 8'b0101_1100,
    ALUOP_SLL = 8'b0111_1100,
    ALUOP_SRL = 8'b0000_0010,
    ALUOP_SRA = 8'b0000_0011
  } aluop_e;

  ////////////////////
  // instruction fields

  typedef enum logic [5:0] {
    OP_SPECIAL = 6'b000000,
    OP_ANDI    = 6'b001100,
    OP_ORI     = 6'b001101,
    OP_XORI    = 6'b001110,
    OP_LUI     = 6'b001111
  } opcode_e;

  typedef enum logic [5:0] {
    FN_SLL  = 6'b000000,
    FN_SRL  = 6'b000010,
    FN_SRA  = 6'b000011,
    FN_SLLV = 6'b000100,
    FN_SRLV = 6'b000110,
    FN_SRAV = 6'b000111,
    FN_AND  = 6'b100100,
    FN_OR   = 6'b100101,
    FN_XOR  = 6'b100110,
    FN_NOR  = 6'b100111
  } funct_e;

  ////////////////////
  // stage bundles

  typedef struct packed {
    alusel_e                  alusel;
    aluop_e                   aluop;
    logic [`OPENMIPS_DW-1:0]  reg1_data;  // shift amount for shifts
    logic [`OPENMIPS_DW-1:0]  reg2_data;
    logic                     wreg;
    logic [`OPENMIPS_RAW-1:0] waddr;
  } id_ex_t;

  typedef struct packed {
    logic                     we;
    logic [`OPENMIPS_RAW-1:0] waddr;
    logic [`OPENMIPS_DW-1:0]  wdata;
  } wb_t;

endpackage

/* hw/pc_reg.sv */
`include "openmips_cfg.svh"

module pc_reg (
  input  logic                    clk,
  input  logic                    rst_n_i,
  output logic [`OPENMIPS_DW-1:0] pc_o,
  output logic                    ce_o
);

  localparam logic [`OPENMIPS_DW-1:0] PC_STEP = 4;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ce_o <= 1'b0;
    end else begin
      ce_o <= 1'b1;  // fetch starts one cycle after reset
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_o <= `OPENMIPS_RESET_PC;
    end else if (!ce_o) begin
      pc_o <= `OPENMIPS_RESET_PC;
    end else begin
      pc_o <= pc_o + PC_STEP;
    end
  end

endmodule

/* hw/id.sv */
`include "openmips_cfg.svh"

module id (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  logic                     ce_i,
  input  logic [`OPENMIPS_DW-1:0]  inst_i,
  input  logic [`OPENMIPS_DW-1:0]  reg1_data_i,
  input  logic [`OPENMIPS_DW-1:0]  reg2_data_i,
  output logic                     reg1_re_o,
  output logic [`OPENMIPS_RAW-1:0] reg1_addr_o,
  output logic                     reg2_re_o,
  output logic [`OPENMIPS_RAW-1:0] reg2_addr_o,
  output openmips_pkg::id_ex_t     id_ex_o
);
  import openmips_pkg::*;

  localparam int DW = `OPENMIPS_DW;

  opcode_e                  op;
  funct_e                   fn;
  logic [`OPENMIPS_RAW-1:0] rs;
  logic [`OPENMIPS_RAW-1:0] rt;
  logic [`OPENMIPS_RAW-1:0] rd;
  logic [4:0]               sa;
  logic [15:0]              imm;
  logic [DW-1:0]            imm1;
  logic [DW-1:0]            imm2;
  logic                     var_shift;
  aluop_e                   aluop_d;
  id_ex_t                   id_ex_d;

  assign op  = opcode_e'(inst_i[31:26]);
  assign rs  = inst_i[25:21];
  assign rt  = inst_i[20:16];
  assign rd  = inst_i[15:11];
  assign sa  = inst_i[10:6];
  assign fn  = funct_e'(inst_i[5:0]);
  assign imm = inst_i[15:0];

  assign reg1_addr_o = rs;
  assign reg2_addr_o = rt;

  ////////////////////
  // operation

  always_comb begin
    case (op)
      OP_SPECIAL: begin
        case (fn)
          FN_OR:           aluop_d = ALUOP_OR;
          FN_AND:          aluop_d = ALUOP_AND;
          FN_XOR:          aluop_d = ALUOP_XOR;
          FN_NOR:          aluop_d = ALUOP_NOR;
          FN_SLL, FN_SLLV: aluop_d = ALUOP_SLL;
          FN_SRL, FN_SRLV: aluop_d = ALUOP_SRL;
          FN_SRA, FN_SRAV: aluop_d = ALUOP_SRA;
          default:         aluop_d = ALUOP_NOP;
        endcase
      end
      OP_ORI:  aluop_d = ALUOP_OR;
      OP_ANDI: aluop_d = ALUOP_AND;
      OP_XORI: aluop_d = ALUOP_XOR;
      OP_LUI:  aluop_d = ALUOP_LUI;
      default: aluop_d = ALUOP_NOP;
    endcase
  end

  ////////////////////
  // operands and destination

  always_comb begin
    reg1_re_o      = 1'b0;
    reg2_re_o      = 1'b0;
    imm1           = '0;
    imm2           = '0;
    var_shift      = 1'b0;
    id_ex_d.alusel = ALUSEL_NOP;
    id_ex_d.aluop  = ALUOP_NOP;
    id_ex_d.wreg   = 1'b0;
    id_ex_d.waddr  = rd;
    if (ce_i) begin
      case (op)
        OP_SPECIAL: begin
          case (fn)
            FN_OR, FN_AND, FN_XOR, FN_NOR: begin
              id_ex_d.alusel = ALUSEL_LOGIC;
              reg1_re_o      = 1'b1;
              reg2_re_o      = 1'b1;
            end
            FN_SLL, FN_SRL, FN_SRA: begin
              id_ex_d.alusel = ALUSEL_SHIFT;
              reg2_re_o      = 1'b1;
              imm1           = {{(DW-5){1'b0}}, sa};
            end
            FN_SLLV, FN_SRLV, FN_SRAV: begin
              id_ex_d.alusel = ALUSEL_SHIFT;
              reg1_re_o      = 1'b1;
              reg2_re_o      = 1'b1;
              var_shift      = 1'b1;
            end
            default: ;
          endcase
        end
        OP_ORI, OP_ANDI, OP_XORI: begin
          id_ex_d.alusel = ALUSEL_LOGIC;
          id_ex_d.waddr  = rt;
          reg1_re_o      = 1'b1;
          imm2           = {{(DW-16){1'b0}}, imm};  // zero extended
        end
        OP_LUI: begin
          id_ex_d.alusel = ALUSEL_LOGIC;
          id_ex_d.waddr  = rt;
          imm2           = {imm, {(DW-16){1'b0}}};
        end
        default: ;
      endcase
    end
    if (id_ex_d.alusel != ALUSEL_NOP) begin
      id_ex_d.aluop = aluop_d;
      id_ex_d.wreg  = (id_ex_d.waddr != '0);  // register 0 is never written
    end
    if (!reg1_re_o) begin
      id_ex_d.reg1_data = imm1;
    end else if (var_shift) begin
      id_ex_d.reg1_data = {{(DW-5){1'b0}}, reg1_data_i[4:0]};
    end else begin
      id_ex_d.reg1_data = reg1_data_i;
    end
    id_ex_d.reg2_data = reg2_re_o ? reg2_data_i : imm2;
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      id_ex_o.alusel <= ALUSEL_NOP;
      id_ex_o.aluop  <= ALUOP_NOP;
      id_ex_o.wreg   <= 1'b0;
    end else begin
      id_ex_o <= id_ex_d;
    end
  end

endmodule

/* hw/regfile.sv */
`include "openmips_cfg.svh"

module regfile (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  logic                     reg1_re_i,
  input  logic [`OPENMIPS_RAW-1:0] reg1_addr_i,
  input  logic                     reg2_re_i,
  input  logic [`OPENMIPS_RAW-1:0] reg2_addr_i,
  output logic [`OPENMIPS_DW-1:0]  reg1_data_o,
  output logic [`OPENMIPS_DW-1:0]  reg2_data_o,
  input  openmips_pkg::wb_t        wb_i
);

  logic [`OPENMIPS_DW-1:0] regs [`OPENMIPS_REG_NUM];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `OPENMIPS_REG_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_i.we && (wb_i.waddr != '0)) begin
      regs[wb_i.waddr] <= wb_i.wdata;
    end
  end

  ////////////////////
  // read ports

  function automatic logic [`OPENMIPS_DW-1:0] read_port(
    input logic                     re,
    input logic [`OPENMIPS_RAW-1:0] addr
  );
    if (!re || (addr == '0)) begin
      return '0;
    end
    if (wb_i.we && (wb_i.waddr == addr)) begin
      return wb_i.wdata;  // same-cycle write is visible to decode
    end
    return regs[addr];
  endfunction

  always_comb begin
    reg1_data_o = read_port(reg1_re_i, reg1_addr_i);
    reg2_data_o = read_port(reg2_re_i, reg2_addr_i);
  end

endmodule

/* hw/ex/alu_logic.sv */
`include "openmips_cfg.svh"

module alu_logic (
  input  openmips_pkg::aluop_e    aluop_i,
  input  logic [`OPENMIPS_DW-1:0] a_i,
  input  logic [`OPENMIPS_DW-1:0] b_i,
  output logic [`OPENMIPS_DW-1:0] result_o
);
  import openmips_pkg::*;

  always_comb begin
    case (aluop_i)
      ALUOP_OR: begin
        result_o = a_i | b_i;
      end
      ALUOP_AND: begin
        result_o = a_i & b_i;
      end
      ALUOP_XOR: begin
        result_o = a_i ^ b_i;
      end
      ALUOP_NOR: begin
        result_o = ~(a_i | b_i);
      end
      ALUOP_LUI: begin
        result_o = b_i;  // decode already moved the immediate up
      end
      default: begin
        result_o = '0;
      end
    endcase
  end

endmodule

/* hw/ex/alu_shift.sv */
`include "openmips_cfg.svh"

module alu_shift (
  input  openmips_pkg::aluop_e             aluop_i,
  input  logic [$clog2(`OPENMIPS_DW)-1:0] shamt_i,
  input  logic [`OPENMIPS_DW-1:0]         data_i,
  output logic [`OPENMIPS_DW-1:0]         result_o
);
  import openmips_pkg::*;

  logic signed [`OPENMIPS_DW-1:0] data_s;

  assign data_s = $signed(data_i);

  always_comb begin
    case (aluop_i)
      ALUOP_SLL: begin
        result_o = data_i << shamt_i;
      end
      ALUOP_SRL: begin
        result_o = data_i >> shamt_i;
      end
      ALUOP_SRA: begin
        result_o = data_s >>> shamt_i;  // fills from bit 31
      end
      default: begin
        result_o = '0;
      end
    endcase
  end

endmodule

/* hw/ex/ex.sv */
`include "openmips_cfg.svh"

module ex (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  openmips_pkg::id_ex_t id_ex_i,
  output openmips_pkg::wb_t    wb_o
);
  import openmips_pkg::*;

  localparam int SW = $clog2(`OPENMIPS_DW);

  logic [`OPENMIPS_DW-1:0] logic_res;
  logic [`OPENMIPS_DW-1:0] shift_res;
  wb_t                     wb_d;

  alu_logic alu_logic0 (
    .aluop_i  (id_ex_i.aluop     ),
    .a_i      (id_ex_i.reg1_data ),
    .b_i      (id_ex_i.reg2_data ),
    .result_o (logic_res         )
  );

  alu_shift alu_shift0 (
    .aluop_i  (id_ex_i.aluop             ),
    .shamt_i  (id_ex_i.reg1_data[SW-1:0] ),
    .data_i   (id_ex_i.reg2_data         ),
    .result_o (shift_res                 )
  );

  ////////////////////
  // result select

  always_comb begin
    wb_d.waddr = id_ex_i.waddr;
    case (id_ex_i.alusel)
      ALUSEL_LOGIC: wb_d.wdata = logic_res;
      ALUSEL_SHIFT: wb_d.wdata = shift_res;
      default:      wb_d.wdata = '0;
    endcase
    wb_d.we = id_ex_i.wreg && (id_ex_i.alusel != ALUSEL_NOP);
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_o.we <= 1'b0;
    end else begin
      wb_o <= wb_d;
    end
  end

endmodule

/* hw/mem.sv */
module mem (
  input  logic              clk,
  input  logic              rst_n_i,
  input  openmips_pkg::wb_t wb_i,
  output openmips_pkg::wb_t wb_o
);

  // no load/store yet so the bundle only moves one stage on
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_o.we <= 1'b0;
    end else begin
      wb_o <= wb_i;
    end
  end

endmodule

/* hw/openmips.sv */
`include "openmips_cfg.svh"

module openmips (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic [`OPENMIPS_DW-1:0] inst_i,
  output logic                    ce_o,
  output logic [`OPENMIPS_DW-1:0] addr_o,
  output openmips_pkg::wb_t       wb_o
);
  import openmips_pkg::*;

  logic [`OPENMIPS_DW-1:0]  pc;
  logic                     reg1_re;
  logic [`OPENMIPS_RAW-1:0] reg1_addr;
  logic [`OPENMIPS_DW-1:0]  reg1_data;
  logic                     reg2_re;
  logic [`OPENMIPS_RAW-1:0] reg2_addr;
  logic [`OPENMIPS_DW-1:0]  reg2_data;
  id_ex_t                   id_ex;
  wb_t                      ex_wb;

  assign addr_o = pc;

  ////////////////////
  // fetch and decode

  pc_reg pc_reg0 (
    .clk     (clk     ),
    .rst_n_i (rst_n_i ),
    .pc_o    (pc      ),
    .ce_o    (ce_o    )
  );

  id id0 (
    .clk         (clk       ),
    .rst_n_i     (rst_n_i   ),
    .ce_i        (ce_o      ),
    .inst_i      (inst_i    ),
    .reg1_data_i (reg1_data ),
    .reg2_data_i (reg2_data ),
    .reg1_re_o   (reg1_re   ),
    .reg1_addr_o (reg1_addr ),
    .reg2_re_o   (reg2_re   ),
    .reg2_addr_o (reg2_addr ),
    .id_ex_o     (id_ex     )
  );

  regfile regfile0 (
    .clk         (clk       ),
    .rst_n_i     (rst_n_i   ),
    .reg1_re_i   (reg1_re   ),
    .reg1_addr_i (reg1_addr ),
    .reg2_re_i   (reg2_re   ),
    .reg2_addr_i (reg2_addr ),
    .reg1_data_o (reg1_data ),
    .reg2_data_o (reg2_data ),
    .wb_i        (wb_o      )  // write port is the top output
  );

  ////////////////////
  // execute and memory

  ex ex0 (
    .clk     (clk     ),
    .rst_n_i (rst_n_i ),
    .id_ex_i (id_ex   ),
    .wb_o    (ex_wb   )
  );

  mem mem0 (
    .clk     (clk     ),
    .rst_n_i (rst_n_i ),
    .wb_i    (ex_wb   ),
    .wb_o    (wb_o    )
  );

endmodule

/* dv/openmips_sva.sv */
`include "openmips_cfg.svh"

module openmips_sva (
  input logic                    clk,
  input logic                    rst_n_i,
  input logic                    ce_o,
  input logic [`OPENMIPS_DW-1:0] addr_o,
  input openmips_pkg::wb_t       wb_o
);

  ////////////////////
  // fetch

  first_fetch_off: assert property (
    @(posedge clk) $rose(rst_n_i) |-> !ce_o
  ) else $error("fetch was enabled in the first cycle after reset");

  pc_step: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    ce_o |=> (addr_o == $past(addr_o) + 32'd4)  // one word per enabled cycle
  ) else $error("fetch address did not advance by 4");

  ////////////////////
  // write-back

  no_zero_write: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    wb_o.we |-> (wb_o.waddr != '0)
  ) else $error("write-back targeted register 0");

endmodule

bind openmips openmips_sva openmips_sva_i (
  .clk     (clk     ),
  .rst_n_i (rst_n_i ),
  .ce_o    (ce_o    ),
  .addr_o  (addr_o  ),
  .wb_o    (wb_o    )
);

/* dv/tb_openmips.sv */
`include "openmips_cfg.svh"

module tb_openmips;
  import openmips_pkg::*;

  localparam int          PROG_LEN   = 200;
  localparam int          IMEM_DEPTH = 256;
  localparam int          TIMEOUT    = 1000;
  localparam logic [31:0] SEED       = 32'h0ca17723;

  logic                    clk;
  logic                    rst_n_i;
  logic [`OPENMIPS_DW-1:0] inst;
  logic                    ce;
  logic [`OPENMIPS_DW-1:0] addr;
  wb_t                     wb;

  logic [31:0] imem [IMEM_DEPTH];
  logic [31:0] model_regs [32];
  int          last_write [32];
  wb_t         exp_q [$];
  int          err_count  = 0;
  int          seen_count = 0;
  int          fetch_cyc  = 0;
  int          exp_count;

  openmips dut_i (
    .clk     (clk     ),
    .rst_n_i (rst_n_i ),
    .inst_i  (inst    ),
    .ce_o    (ce      ),
    .addr_o  (addr    ),
    .wb_o    (wb      )
  );

  always #5 clk = ~clk;

  assign inst = (addr[31:10] == '0) ? imem[addr[9:2]] : '0;  // past the array reads as nop

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Mismatch %s: got %h expected %h", name, actual, expected);
      err_count++;
    end
  endtask

  ////////////////////
  // encoding and model

  function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] rd, input logic [4:0] sa,
                                         input logic [5:0] fn);
    return {6'b000000, rs, rt, rd, sa, fn};
  endfunction

  function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic wb_t model_exec(input logic [31:0] iw);
    wb_t         w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_z;
    logic [4:0]  sa;
    a       = model_regs[iw[25:21]];
    b       = model_regs[iw[20:16]];
    imm_z   = {16'h0000, iw[15:0]};
    sa      = iw[10:6];
    w.we    = 1'b1;
    w.waddr = iw[20:16];
    w.wdata = '0;
    case (iw[31:26])
      6'h0d: w.wdata = a | imm_z;
      6'h0c: w.wdata = a & imm_z;
      6'h0e: w.wdata = a ^ imm_z;
      6'h0f: w.wdata = {iw[15:0], 16'h0000};
      6'h00: begin
        w.waddr = iw[15:11];
        case (iw[5:0])
          6'h25:   w.wdata = a | b;
          6'h24:   w.wdata = a & b;
          6'h26:   w.wdata = a ^ b;
          6'h27:   w.wdata = ~(a | b);
          6'h00:   w.wdata = b << sa;
          6'h02:   w.wdata = b >> sa;
          6'h03:   w.wdata = $signed(b) >>> sa;
          6'h04:   w.wdata = b << a[4:0];
          6'h06:   w.wdata = b >> a[4:0];
          6'h07:   w.wdata = $signed(b) >>> a[4:0];
          default: w.we = 1'b0;
        endcase
      end
      default: w.we = 1'b0;
    endcase
    if (w.waddr == 5'd0) begin
      w.we = 1'b0;  // register 0 stays zero
    end
    if (w.we) begin
      model_regs[w.waddr] = w.wdata;
    end
    return w;
  endfunction

  ////////////////////
  // program

  function automatic logic [4:0] pick_source(input int idx);
    logic [4:0] r;
    r = 5'($urandom);
    while ((r != 5'd0) && (idx - last_write[r] < 3)) begin
      r = 5'($urandom);  // producer still in flight without forwarding
    end
    return r;
  endfunction

  task automatic build_program();
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [31:0] iw;
    wb_t         w;
    for (int i = 0; i < IMEM_DEPTH; i++) begin
      imem[i] = '0;
    end
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
      last_write[r] = -10;
    end
    for (int n = 0; n < PROG_LEN; n++) begin
      rs = pick_source(n);
      rt = pick_source(n);
      rd = 5'($urandom);
      if (n < 31) begin
        iw = i_type(6'h0f, 5'd0, 5'(n + 1), 16'($urandom));
      end else if (n < 62) begin
        iw = i_type(6'h0d, 5'(n - 30), 5'(n - 30), 16'($urandom));
      end else begin
        case ($urandom_range(14, 0))
          0:       iw = i_type(6'h0d, rs, rd, 16'($urandom));
          1:       iw = i_type(6'h0c, rs, rd, 16'($urandom));
          2:       iw = i_type(6'h0e, rs, rd, 16'($urandom));
          3:       iw = i_type(6'h0f, 5'd0, rd, 16'($urandom));
          4:       iw = r_type(rs, rt, rd, 5'd0, 6'h25);
          5:       iw = r_type(rs, rt, rd, 5'd0, 6'h24);
          6:       iw = r_type(rs, rt, rd, 5'd0, 6'h26);
          7:       iw = r_type(rs, rt, rd, 5'd0, 6'h27);
          8:       iw = r_type(5'd0, rt, rd, 5'($urandom), 6'h00);
          9:       iw = r_type(5'd0, rt, rd, 5'($urandom), 6'h02);
          10:      iw = r_type(5'd0, rt, rd, 5'($urandom), 6'h03);
          11:      iw = r_type(rs, rt, rd, 5'd0, 6'h04);
          12:      iw = r_type(rs, rt, rd, 5'd0, 6'h06);
          13:      iw = r_type(rs, rt, rd, 5'd0, 6'h07);
          default: iw = '0;
        endcase
      end
      imem[8'(n)] = iw;
      w = model_exec(iw);
      if (w.we) begin
        exp_q.push_back(w);
        last_write[w.waddr] = n;
      end
    end
  endtask

  ////////////////////
  // compare

  always @(negedge clk) begin
    wb_t exp_w;
    if (rst_n_i) begin
      if (fetch_cyc == 0) begin
        compare_value("ce_o", 32'(ce), 32'd0);
      end else begin
        compare_value("ce_o", 32'(ce), 32'd1);
        compare_value("addr_o", addr, 32'((fetch_cyc - 1) * 4));
      end
      fetch_cyc++;
      if (wb.we) begin
        seen_count++;
        if (exp_q.size() == 0) begin
          $display("write to register %0d arrived with no instruction left to expect it",
                   wb.waddr);
          err_count++;
        end else begin
          exp_w = exp_q.pop_front();
          compare_value("wb_o.waddr", 32'(wb.waddr), 32'(exp_w.waddr));
          compare_value("wb_o.wdata", wb.wdata, exp_w.wdata);
        end
      end
    end
  end

  initial begin
    int   cyc;
    int   fails;
    logic done;
    logic timed_out;
    clk       = 1'b0;
    rst_n_i   = 1'b0;
    cyc       = 0;
    done      = 1'b0;
    timed_out = 1'b0;
    void'($urandom(SEED));
    build_program();
    exp_count = exp_q.size();
    repeat (2) @(posedge clk);
    rst_n_i <= 1'b1;
    while (!done && !timed_out) begin
      @(posedge clk);
      cyc++;
      // trailing cycles catch extra writes
      done      = (exp_q.size() == 0) && (fetch_cyc > PROG_LEN + 8);
      timed_out = !done && (cyc >= TIMEOUT);
    end
    fails = err_count + exp_q.size();
    if (timed_out) begin
      $display("timeout: the program did not drain within %0d cycles", TIMEOUT);
      fails++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d expected writes never appeared on wb_o", exp_q.size());
    end
    if (seen_count != exp_count) begin
      $display("number of writes seen differs from the number expected");
      fails++;
    end
    $display("errors: %0d, writes seen: %0d, writes expected: %0d", fails, seen_count, exp_count);
    if (fails == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+common
common/openmips_pkg.sv
hw/pc_reg.sv
hw/id.sv
hw/regfile.sv
hw/ex/alu_logic.sv
hw/ex/alu_shift.sv
hw/ex/ex.sv
hw/mem.sv
hw/openmips.sv
dv/openmips_sva.sv
dv/tb_openmips.sv

/* run.sh */
#!/bin/sh
# build and run the openmips testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_openmips \
  -o tb_openmips > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "build failed"
  exit 1
fi

./obj_dir/tb_openmips > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "RESULT: FAIL" "$SIM_LOG"; then
  exit 1
fi
exit 0
